//--- list.f
logic/cpu_pkg.sv
logic/pipe_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/cpu_core.sv
bench/cpu_tb_assert.sv
bench/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Compile the core and its testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cpu_tb -f list.f -o cpu_tb_sim \
    && ./obj_dir/cpu_tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Everything OK$" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation did not pass"; exit 1; }

//--- bench/cpu_tb.sv
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC  = 32'h0000_0080;
    localparam int          MEM_WORDS = 1024;
    localparam int          SUB_IDX   = int'(RESET_PC >> 2) + 200; // Subroutine location.
    localparam int          FIRST_RETIRE = 4; // Release edge plus decode, execute, result.

    // MIPS-I encodings.
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_MFHI    = 6'h10;
    localparam logic [5:0] FN_MFLO    = 6'h12;
    localparam logic [5:0] FN_MULTU   = 6'h19;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    typedef struct packed {
        logic [31:0] pc;
        logic        wen;
        logic [4:0]  rd;
        logic [31:0] data;
    } retire_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data = '0;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_wen;
    logic [4:0]  retire_reg;
    logic [31:0] retire_data;

    logic [31:0] mem [MEM_WORDS];
    int          wp;
    int          prog_len;
    logic [31:0] loop_pc;
    logic        built = 1'b0;
    logic [31:0] m_pc;
    logic [31:0] m_npc;     // Delay-slot successor.
    logic [31:0] m_hi;
    logic [31:0] m_lo;
    logic [31:0] m_regs [32];
    int          errors;
    int          retires;
    int          loop_hits;
    int          edges;
    retire_t     expected;

    cpu_core #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_reg   (retire_reg),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        imem_data <= mem[imem_addr[11:2]]; // One-cycle read latency.
    end

    function automatic logic [31:0] r_type(input logic [5:0] fn, input int rs, input int rt,
                                           input int rd, input int sa);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input int rs, input int rt,
                                           input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] j_type(input logic [5:0] op, input int target);
        return {op, target[27:2]};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[wp] = word;
        wp++;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] v;
        int          ret_wp;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
        wp = int'(RESET_PC >> 2);
        for (int i = 1; i <= 8; i++) begin
            v = $urandom();
            emit(i_type(OP_LUI, 0, i, v >> 16));
            emit(i_type(OP_ORI, i, i, v));
        end
        emit(r_type(FN_ADDU, 1, 2, 9, 0));
        emit(r_type(FN_SUBU, 9, 3, 10, 0));   // Execute forward.
        emit(r_type(FN_AND, 10, 9, 11, 0));   // Both forward paths at once.
        emit(r_type(FN_OR, 11, 4, 12, 0));
        emit(r_type(FN_SLT, 12, 5, 13, 0));
        emit(r_type(FN_SLT, 6, 12, 14, 0));
        emit(r_type(FN_SLL, 0, 13, 15, 5));
        emit(i_type(OP_ADDIU, 15, 15, -3));
        emit(i_type(OP_ORI, 14, 16, 'ha5a5));
        emit(i_type(OP_LUI, 0, 17, 'h1234));
        emit(r_type(FN_ADDU, 16, 17, 18, 0));
        emit(r_type(FN_SUBU, 15, 18, 19, 0));
        emit(r_type(FN_ADDU, 1, 2, 0, 0));    // Write to r0.
        emit(r_type(FN_OR, 0, 3, 20, 0));
        emit(i_type(OP_ADDIU, 0, 0, 'h7fff));
        emit(r_type(FN_ADDU, 0, 0, 20, 0));
        emit(i_type(OP_BEQ, 1, 1, 2));        // Taken.
        emit(i_type(OP_ADDIU, 0, 21, 1));
        emit(i_type(OP_ADDIU, 21, 21, 100));  // Skipped.
        emit(i_type(OP_BNE, 1, 1, 2));        // Not taken.
        emit(i_type(OP_ADDIU, 21, 22, 7));
        emit(i_type(OP_ADDIU, 22, 22, 1));
        emit(i_type(OP_ADDIU, 0, 24, 5));
        emit(i_type(OP_BNE, 24, 0, 2));       // Compare on a forwarded operand.
        emit(i_type(OP_ADDIU, 24, 24, 1));
        emit(i_type(OP_ADDIU, 24, 24, 64));
        for (int r = 1; r <= 8; r++) begin
            if (r % 2 == 1) begin
                emit(i_type(OP_REGIMM, r, 1, 2)); // BGEZ.
            end else begin
                emit(i_type(OP_BGTZ, r, 0, 2));
            end
            emit(i_type(OP_ADDIU, 23, 23, 1));
            emit(i_type(OP_ADDIU, 23, 23, r * 16));
        end
        emit(i_type(OP_BGTZ, 0, 0, 2));
        emit(i_type(OP_ADDIU, 23, 23, 3));
        emit(i_type(OP_REGIMM, 0, 1, 2));
        emit(i_type(OP_ADDIU, 23, 23, 5));
        emit(i_type(OP_ADDIU, 23, 23, 512));
        emit(i_type(OP_ADDIU, 0, 25, 3));
        emit(i_type(OP_ADDIU, 25, 25, -1));   // Backward loop body.
        emit(i_type(OP_BNE, 25, 0, -2));
        emit(32'h0000_0000);
        emit(j_type(OP_J, (wp + 3) * 4));
        emit(i_type(OP_ADDIU, 0, 26, 3));
        emit(i_type(OP_ADDIU, 26, 26, 9));
        emit(j_type(OP_JAL, SUB_IDX * 4));
        emit(i_type(OP_ADDIU, 0, 27, 11));
        emit(r_type(FN_MULTU, 1, 2, 0, 0));
        emit(r_type(FN_MFHI, 0, 0, 28, 0));
        emit(r_type(FN_MFLO, 0, 0, 29, 0));
        emit(i_type(OP_ADDIU, 6, 6, 1));
        emit(r_type(FN_MULTU, 5, 6, 0, 0));
        emit(r_type(FN_MFLO, 0, 0, 30, 0));
        emit(r_type(FN_MFHI, 0, 0, 7, 0));
        loop_pc = wp * 4;
        emit(j_type(OP_J, wp * 4));
        emit(32'h0000_0000);
        ret_wp = wp;
        wp = SUB_IDX;
        emit(r_type(FN_ADDU, 31, 1, 19, 0));
        emit(r_type(FN_JR, 31, 0, 0, 0));
        emit(i_type(OP_ADDIU, 27, 27, 2));
        wp = ret_wp;
    endtask

    // One instruction of the ISA on the model state.
    function automatic retire_t model_step();
        retire_t     r;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] after;
        logic [63:0] prod;
        ins    = mem[m_pc[11:2]];
        a      = m_regs[ins[25:21]];
        b      = m_regs[ins[20:16]];
        simm   = {{16{ins[15]}}, ins[15:0]};
        after  = m_npc + 32'd4;
        r.pc   = m_pc;
        r.wen  = 1'b0;
        r.rd   = 5'd0;
        r.data = 32'd0;
        case (ins[31:26])
            OP_SPECIAL: begin
                r.rd  = ins[15:11];
                r.wen = 1'b1;
                case (ins[5:0])
                    FN_SLL:  r.data = b << ins[10:6];
                    FN_ADDU: r.data = a + b;
                    FN_SUBU: r.data = a - b;
                    FN_AND:  r.data = a & b;
                    FN_OR:   r.data = a | b;
                    FN_SLT:  r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_MFHI: r.data = m_hi;
                    FN_MFLO: r.data = m_lo;
                    FN_JR: begin
                        r.wen = 1'b0;
                        after = a;
                    end
                    FN_MULTU: begin
                        r.wen = 1'b0;
                        prod  = {32'd0, a} * {32'd0, b};
                        m_hi  = prod[63:32];
                        m_lo  = prod[31:0];
                    end
                    default: r.wen = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                if (ins[20:16] == 5'd1 && !a[31]) begin
                    after = m_npc + (simm << 2);
                end
            end
            OP_BEQ:  if (a == b) after = m_npc + (simm << 2);
            OP_BNE:  if (a != b) after = m_npc + (simm << 2);
            OP_BGTZ: if (!a[31] && a != 32'd0) after = m_npc + (simm << 2);
            OP_J:    after = {m_npc[31:28], ins[25:0], 2'b00};
            OP_JAL: begin
                after  = {m_npc[31:28], ins[25:0], 2'b00};
                r.wen  = 1'b1;
                r.rd   = 5'd31;
                r.data = m_pc + 32'd8;
            end
            OP_ADDIU: begin
                r.wen  = 1'b1;
                r.rd   = ins[20:16];
                r.data = a + simm;
            end
            OP_ORI: begin
                r.wen  = 1'b1;
                r.rd   = ins[20:16];
                r.data = a | {16'h0000, ins[15:0]};
            end
            OP_LUI: begin
                r.wen  = 1'b1;
                r.rd   = ins[20:16];
                r.data = {ins[15:0], 16'h0000};
            end
            default: ;
        endcase
        if (r.rd == 5'd0) begin
            r.wen = 1'b0;
        end
        if (r.wen) begin
            m_regs[r.rd] = r.data;
        end
        m_pc  = m_npc;
        m_npc = after;
        return r;
    endfunction

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("[FAIL] %0t ns: %s is %h, expected %h", $time, field, got, want);
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            if (imem_addr !== RESET_PC) begin
                report_mismatch("imem_addr in reset", imem_addr, RESET_PC);
            end
        end else begin
            edges++;
            if (retire_valid === 1'b1) begin
                if (retires == 0 && edges != FIRST_RETIRE) begin
                    errors++;
                    $display("First retire came %0d cycles after reset release, not 3",
                             edges - 1);
                end
                expected = model_step();
                retires++;
                if (retire_pc !== expected.pc) begin
                    report_mismatch("retire_pc", retire_pc, expected.pc);
                end
                if (retire_wen !== expected.wen) begin
                    report_mismatch("retire_wen", 32'(retire_wen), 32'(expected.wen));
                end
                if (expected.wen && retire_reg !== expected.rd) begin
                    report_mismatch("retire_reg", 32'(retire_reg), 32'(expected.rd));
                end
                if (expected.wen && retire_data !== expected.data) begin
                    report_mismatch("retire_data", retire_data, expected.data);
                end
                if (retire_pc == loop_pc) begin
                    loop_hits++;
                end
            end else if (retires > 0) begin
                errors++;
                $display("No retire in the cycle at %0t ns after %0d retires", $time, retires);
            end
        end
    end

    initial begin
        wait (built);
        #((prog_len + 20) * 8 * 4);
        $display("Timeout: the program never reached its final loop");
        $display("Something failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        void'($urandom(81408));
        build_program();
        m_pc  = RESET_PC;
        m_npc = RESET_PC + 32'd4;
        m_hi  = '0;
        m_lo  = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        built = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait (loop_hits >= 3);
        @(posedge clk);
        $display("Retired %0d instructions, %0d errors", retires, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/cpu_tb_assert.sv
`default_nettype none

module cpu_tb_assert (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] imem_addr,
    input logic        retire_valid,
    input logic        retire_wen,
    input logic [4:0]  retire_reg
);
    timeunit 1ns;
    timeprecision 1ps;

    imem_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) imem_addr[1:0] == 2'b00
    ) else $error("imem_addr %h is not word aligned", imem_addr);

    wen_has_dest: assert property (
        @(posedge clk) disable iff (!rst_n) retire_wen |-> retire_reg != 5'd0
    ) else $error("retire_wen is set with retire_reg at zero");

    valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(retire_valid)
    ) else $error("retire_valid is unknown after reset");

    // Flops are cleared by the first edge of reset, so check between edges.
    quiet_in_reset: assert property (
        @(negedge clk) !rst_n |-> !retire_valid
    ) else $error("retire_valid is high while reset is applied");

endmodule

bind cpu_core cpu_tb_assert i_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_addr    (imem_addr),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_reg   (retire_reg)
);

`default_nettype wire

//--- logic/cpu_core.sv
`default_nettype none

module cpu_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                             clk,
    input  logic                             rst_n,
    output logic [cpu_pkg::DATA_W-1:0]       imem_addr,
    input  logic [cpu_pkg::DATA_W-1:0]       imem_data,
    output logic                             retire_valid,
    output logic [cpu_pkg::DATA_W-1:0]       retire_pc,
    output logic                             retire_wen,
    output logic [cpu_pkg::REG_ADDR_W-1:0]   retire_reg,
    output logic [cpu_pkg::DATA_W-1:0]       retire_data
);

    fetch_decode_if   fd_if ();
    decode_execute_if de_if ();
    execute_result_if er_if ();

    logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr;
    logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr;
    logic [cpu_pkg::DATA_W-1:0]     rs_rdata;
    logic [cpu_pkg::DATA_W-1:0]     rt_rdata;
    logic                           we;
    logic [cpu_pkg::REG_ADDR_W-1:0] waddr;
    logic [cpu_pkg::DATA_W-1:0]     wdata;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fd        (fd_if.fetch)
    );

    decode_stage i_decode (
        .fd       (fd_if.decode),
        .de       (de_if.decode),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_rdata (rs_rdata),
        .rt_rdata (rt_rdata),
        .res_wen  (we),          // Result-stage write is the second forward source.
        .res_dest (waddr),
        .res_data (wdata)
    );

    register_file i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_rdata (rs_rdata),
        .rt_rdata (rt_rdata),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata)
    );

    execute_stage i_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .de    (de_if.execute),
        .er    (er_if.execute)
    );

    result_stage i_result (
        .er           (er_if.result),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_reg   (retire_reg),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

//--- logic/result_stage.sv
`default_nettype none

module result_stage (
    execute_result_if.result                 er,
    output logic                             we,
    output logic [cpu_pkg::REG_ADDR_W-1:0]   waddr,
    output logic [cpu_pkg::DATA_W-1:0]       wdata,
    output logic                             retire_valid,
    output logic [cpu_pkg::DATA_W-1:0]       retire_pc,
    output logic                             retire_wen,
    output logic [cpu_pkg::REG_ADDR_W-1:0]   retire_reg,
    output logic [cpu_pkg::DATA_W-1:0]       retire_data
);

    assign we    = er.valid & er.wen & (er.dest != '0); // Writes to r0 drop here.
    assign waddr = er.dest;
    assign wdata = er.data;

    assign retire_valid = er.valid;
    assign retire_pc    = er.pc;
    assign retire_wen   = we;
    assign retire_reg   = er.dest;
    assign retire_data  = er.data;

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    decode_execute_if.execute   de,
    execute_result_if.execute   er
);

    logic                           valid_q;
    logic [cpu_pkg::DATA_W-1:0]     pc_q;
    cpu_pkg::alu_op_t               alu_op_q;
    cpu_pkg::src_b_t                src_b_q;
    logic [cpu_pkg::DATA_W-1:0]     rs_q;
    logic [cpu_pkg::DATA_W-1:0]     rt_q;
    logic [cpu_pkg::IMM_W-1:0]      imm_q;
    logic [cpu_pkg::REG_ADDR_W-1:0] sa_q;
    logic [cpu_pkg::REG_ADDR_W-1:0] dest_q;
    logic                           wen_q;
    logic                           is_multu_q;
    logic [cpu_pkg::DATA_W-1:0]     op_b;
    logic [cpu_pkg::DATA_W-1:0]     alu_out;
    logic [cpu_pkg::DATA_W-1:0]     hi;
    logic [cpu_pkg::DATA_W-1:0]     lo;
    logic [2*cpu_pkg::DATA_W-1:0]   product;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= de.valid;
        end
    end

    always_ff @(posedge clk) begin
        pc_q       <= de.pc;
        alu_op_q   <= de.alu_op;
        src_b_q    <= de.src_b;
        rs_q       <= de.rs_data;
        rt_q       <= de.rt_data;
        imm_q      <= de.imm;
        sa_q       <= de.sa;
        dest_q     <= de.dest;
        wen_q      <= de.wen;
        is_multu_q <= de.is_multu;
    end

    always_comb begin
        case (src_b_q)
            cpu_pkg::SRC_ZIMM: op_b = {16'h0000, imm_q};
            cpu_pkg::SRC_SIMM: op_b = {{16{imm_q[15]}}, imm_q};
            default:           op_b = rt_q;
        endcase
    end

    always_comb begin
        case (alu_op_q)
            cpu_pkg::ALU_ADD:  alu_out = rs_q + op_b;
            cpu_pkg::ALU_SUB:  alu_out = rs_q - op_b;
            cpu_pkg::ALU_AND:  alu_out = rs_q & op_b;
            cpu_pkg::ALU_OR:   alu_out = rs_q | op_b;
            cpu_pkg::ALU_SLT:  alu_out = {31'd0, $signed(rs_q) < $signed(op_b)};
            cpu_pkg::ALU_SLL:  alu_out = rt_q << sa_q;
            cpu_pkg::ALU_LUI:  alu_out = {imm_q, 16'h0000};
            cpu_pkg::ALU_LINK: alu_out = pc_q + 32'd8;
            cpu_pkg::ALU_MFHI: alu_out = hi;
            cpu_pkg::ALU_MFLO: alu_out = lo;
            default:           alu_out = '0;
        endcase
    end

    assign product = {32'd0, rs_q} * {32'd0, rt_q};

    // Written at the end of MULTU's cycle, so a following MFHI or MFLO sees it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (valid_q && is_multu_q) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

    assign de.fwd_data = alu_out;
    assign de.fwd_dest = dest_q;
    assign de.fwd_wen  = valid_q & wen_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            er.valid <= 1'b0;
        end else begin
            er.valid <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        er.pc   <= pc_q;
        er.dest <= dest_q;
        er.wen  <= wen_q;
        er.data <= alu_out;
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

module register_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]   rs_addr,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]   rt_addr,
    output logic [cpu_pkg::DATA_W-1:0]       rs_rdata,
    output logic [cpu_pkg::DATA_W-1:0]       rt_rdata,
    input  logic                             we,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]   waddr,
    input  logic [cpu_pkg::DATA_W-1:0]       wdata
);

    logic [cpu_pkg::DATA_W-1:0] regs [32];
    logic                       wr_ok;

    assign wr_ok = we && (waddr != '0); // r0 stays zero.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write shows through.
    assign rs_rdata = (wr_ok && waddr == rs_addr) ? wdata : regs[rs_addr];
    assign rt_rdata = (wr_ok && waddr == rt_addr) ? wdata : regs[rt_addr];

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none

module decode_stage (
    fetch_decode_if.decode                   fd,
    decode_execute_if.decode                 de,
    output logic [cpu_pkg::REG_ADDR_W-1:0]   rs_addr,
    output logic [cpu_pkg::REG_ADDR_W-1:0]   rt_addr,
    input  logic [cpu_pkg::DATA_W-1:0]       rs_rdata,
    input  logic [cpu_pkg::DATA_W-1:0]       rt_rdata,
    input  logic                             res_wen,
    input  logic [cpu_pkg::REG_ADDR_W-1:0]   res_dest,
    input  logic [cpu_pkg::DATA_W-1:0]       res_data
);

    logic [5:0]                     op;
    logic [5:0]                     funct;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs;
    logic [cpu_pkg::REG_ADDR_W-1:0] rt;
    logic [cpu_pkg::REG_ADDR_W-1:0] rd;
    logic [cpu_pkg::IMM_W-1:0]      imm;
    logic [cpu_pkg::DATA_W-1:0]     rs_val;
    logic [cpu_pkg::DATA_W-1:0]     rt_val;
    logic [cpu_pkg::DATA_W-1:0]     pc_plus4;
    logic [cpu_pkg::DATA_W-1:0]     br_target;
    logic                           eq;
    logic                           gtz;
    logic                           gez;
    cpu_pkg::alu_op_t               alu_op;
    cpu_pkg::src_b_t                src_b;
    logic [cpu_pkg::REG_ADDR_W-1:0] dest;
    logic                           wen;
    logic                           is_multu;
    logic                           is_jr;
    logic                           is_j;
    logic                           is_br;
    logic                           br_taken;
    logic                           redirect;

    assign op    = fd.instr[31:26];
    assign rs    = fd.instr[25:21];
    assign rt    = fd.instr[20:16];
    assign rd    = fd.instr[15:11];
    assign imm   = fd.instr[15:0];
    assign funct = fd.instr[5:0];

    assign rs_addr = rs;
    assign rt_addr = rt;

    // Execute result first, then the one being written back.
    function automatic logic [cpu_pkg::DATA_W-1:0] fwd_operand(
        input logic [cpu_pkg::REG_ADDR_W-1:0] addr,
        input logic [cpu_pkg::DATA_W-1:0]     rf_data
    );
        if (addr == '0) begin
            return rf_data;
        end else if (de.fwd_wen && de.fwd_dest == addr) begin
            return de.fwd_data;
        end else if (res_wen && res_dest == addr) begin
            return res_data;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs_val = fwd_operand(rs, rs_rdata);
        rt_val = fwd_operand(rt, rt_rdata);
    end

    assign eq  = (rs_val == rt_val);
    assign gez = ~rs_val[31];
    assign gtz = ~rs_val[31] & (|rs_val);

    always_comb begin
        alu_op   = cpu_pkg::ALU_NONE;
        src_b    = cpu_pkg::SRC_REG;
        dest     = rd;
        wen      = 1'b0;
        is_multu = 1'b0;
        is_jr    = 1'b0;
        is_j     = 1'b0;
        is_br    = 1'b0;
        br_taken = 1'b0;
        case (op)
            cpu_pkg::OP_SPECIAL: begin
                wen = 1'b1;
                case (funct)
                    cpu_pkg::FN_SLL:   alu_op = cpu_pkg::ALU_SLL;
                    cpu_pkg::FN_MFHI:  alu_op = cpu_pkg::ALU_MFHI;
                    cpu_pkg::FN_MFLO:  alu_op = cpu_pkg::ALU_MFLO;
                    cpu_pkg::FN_ADDU:  alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUBU:  alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:   alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:    alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT:   alu_op = cpu_pkg::ALU_SLT;
                    cpu_pkg::FN_JR: begin
                        wen   = 1'b0;
                        is_jr = 1'b1;
                    end
                    cpu_pkg::FN_MULTU: begin
                        wen      = 1'b0;
                        is_multu = 1'b1;
                    end
                    default:           wen = 1'b0;
                endcase
            end
            cpu_pkg::OP_REGIMM: begin
                is_br    = (rt == cpu_pkg::RT_BGEZ);
                br_taken = (rt == cpu_pkg::RT_BGEZ) && gez;
            end
            cpu_pkg::OP_J:      is_j = 1'b1;
            cpu_pkg::OP_JAL: begin
                is_j   = 1'b1;
                alu_op = cpu_pkg::ALU_LINK;
                dest   = cpu_pkg::LINK_REG;
                wen    = 1'b1;
            end
            cpu_pkg::OP_BEQ: begin
                is_br    = 1'b1;
                br_taken = eq;
            end
            cpu_pkg::OP_BNE: begin
                is_br    = 1'b1;
                br_taken = ~eq;
            end
            cpu_pkg::OP_BGTZ: begin
                is_br    = 1'b1;
                br_taken = gtz;
            end
            cpu_pkg::OP_ADDIU: begin
                alu_op = cpu_pkg::ALU_ADD;
                src_b  = cpu_pkg::SRC_SIMM;
                dest   = rt;
                wen    = 1'b1;
            end
            cpu_pkg::OP_ORI: begin
                alu_op = cpu_pkg::ALU_OR;
                src_b  = cpu_pkg::SRC_ZIMM;
                dest   = rt;
                wen    = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                alu_op = cpu_pkg::ALU_LUI;
                dest   = rt;
                wen    = 1'b1;
            end
            default: ;
        endcase
    end

    // A control transfer sitting in a delay slot is not followed.
    assign redirect  = fd.valid & ~fd.in_delay_slot;
    assign pc_plus4  = fd.pc + 32'd4;
    assign br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};

    always_comb begin
        if (redirect && is_jr) begin
            fd.next_pc = rs_val;
        end else if (redirect && is_j) begin
            fd.next_pc = {pc_plus4[31:28], fd.instr[25:0], 2'b00};
        end else if (redirect && br_taken) begin
            fd.next_pc = br_target;
        end else begin
            fd.next_pc = fd.fetch_pc + 32'd4;
        end
    end

    assign fd.next_in_delay_slot = redirect & (is_jr | is_j | is_br);

    assign de.valid    = fd.valid;
    assign de.pc       = fd.pc;
    assign de.alu_op   = alu_op;
    assign de.src_b    = src_b;
    assign de.rs_data  = rs_val;
    assign de.rt_data  = rt_val;
    assign de.imm      = imm;
    assign de.sa       = fd.instr[10:6];
    assign de.dest     = dest;
    assign de.wen      = wen;
    assign de.is_multu = is_multu;

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`default_nettype none

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [cpu_pkg::DATA_W-1:0] imem_addr,
    input  logic [cpu_pkg::DATA_W-1:0] imem_data,
    fetch_decode_if.fetch              fd
);

    logic [cpu_pkg::DATA_W-1:0] pc_reg;
    logic [cpu_pkg::DATA_W-1:0] fetched_pc;
    logic                       valid_q;
    logic                       in_ds_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_reg  <= RESET_PC;
            valid_q <= 1'b0;
            in_ds_q <= 1'b0;
        end else begin
            pc_reg  <= fd.next_pc;
            valid_q <= 1'b1;                  // Word for pc_reg arrives next cycle.
            in_ds_q <= fd.next_in_delay_slot;
        end
    end

    // Lines up with imem_data one cycle later.
    always_ff @(posedge clk) begin
        fetched_pc <= pc_reg;
    end

    assign imem_addr        = pc_reg;
    assign fd.fetch_pc      = pc_reg;
    assign fd.pc            = fetched_pc;
    assign fd.instr         = imem_data;
    assign fd.valid         = valid_q;
    assign fd.in_delay_slot = in_ds_q;

endmodule

`default_nettype wire

//--- logic/pipe_if.sv
`default_nettype none

interface fetch_decode_if;
    logic [cpu_pkg::DATA_W-1:0] fetch_pc;  // Address now on imem_addr.
    logic [cpu_pkg::DATA_W-1:0] pc;        // Address of instr.
    logic [cpu_pkg::DATA_W-1:0] instr;
    logic                       valid;
    logic                       in_delay_slot;
    logic [cpu_pkg::DATA_W-1:0] next_pc;
    logic                       next_in_delay_slot;

    modport fetch (output fetch_pc, pc, instr, valid, in_delay_slot,
                   input  next_pc, next_in_delay_slot);
    modport decode (input  fetch_pc, pc, instr, valid, in_delay_slot,
                    output next_pc, next_in_delay_slot);
endinterface

interface decode_execute_if;
    logic                           valid;
    logic [cpu_pkg::DATA_W-1:0]     pc;
    cpu_pkg::alu_op_t               alu_op;
    cpu_pkg::src_b_t                src_b;
    logic [cpu_pkg::DATA_W-1:0]     rs_data;
    logic [cpu_pkg::DATA_W-1:0]     rt_data;
    logic [cpu_pkg::IMM_W-1:0]      imm;
    logic [cpu_pkg::REG_ADDR_W-1:0] sa;
    logic [cpu_pkg::REG_ADDR_W-1:0] dest;
    logic                           wen;
    logic                           is_multu;
    // Forward path back from execute.
    logic [cpu_pkg::DATA_W-1:0]     fwd_data;
    logic [cpu_pkg::REG_ADDR_W-1:0] fwd_dest;
    logic                           fwd_wen;

    modport decode (output valid, pc, alu_op, src_b, rs_data, rt_data, imm, sa,
                           dest, wen, is_multu,
                    input  fwd_data, fwd_dest, fwd_wen);
    modport execute (input  valid, pc, alu_op, src_b, rs_data, rt_data, imm, sa,
                            dest, wen, is_multu,
                     output fwd_data, fwd_dest, fwd_wen);
endinterface

interface execute_result_if;
    logic                           valid;
    logic [cpu_pkg::DATA_W-1:0]     pc;
    logic [cpu_pkg::REG_ADDR_W-1:0] dest;
    logic                           wen;
    logic [cpu_pkg::DATA_W-1:0]     data;

    modport execute (output valid, pc, dest, wen, data);
    modport result (input valid, pc, dest, wen, data);
endinterface

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31; // JAL destination.

    // Primary opcodes in instr[31:26].
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [4:0] RT_BGEZ = 5'h01; // REGIMM selector in rt.

    // SPECIAL funct codes in instr[5:0].
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI,
        ALU_LINK,  // Return address, pc + 8.
        ALU_MFHI,
        ALU_MFLO,
        ALU_NONE
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_REG,
        SRC_ZIMM,
        SRC_SIMM
    } src_b_t;

endpackage

`default_nettype wire
